//--- source/intr_ctrl_params.svh
`ifndef INTR_CTRL_PARAMS_SVH
`define INTR_CTRL_PARAMS_SVH

// context index width and number of contexts
`define INTR_CTXT_W 4
`define INTR_NCTXT 16

// interrupt sources per context
`define INTR_NSRC 6

// msi number carried with each interrupt
`define INTR_MSI_W 8

// mmio data word and register offset
`define INTR_DATA_W 64
`define INTR_OFF_W 4

`endif

//--- source/intr_types_pkg.sv
`include "intr_ctrl_params.svh"

package intr_types_pkg;

   // context index
   typedef logic [`INTR_CTXT_W-1:0] ctxt_t;

   // one bit per interrupt source, used for status and mask
   typedef logic [`INTR_NSRC-1:0] src_vec_t;

   // encoded source number of an inbound error
   typedef logic [$clog2(`INTR_NSRC)-1:0] src_id_t;

   typedef logic [`INTR_MSI_W-1:0] msi_t;

   // kinds of update, listed in arbitration priority
   typedef enum logic [1:0] {
      UPD_ADD = 2'd0,
      UPD_WR  = 2'd1,
      UPD_ERR = 2'd2
   } upd_kind_t;

endpackage

//--- source/intr_regs_pkg.sv
`include "intr_ctrl_params.svh"

package intr_regs_pkg;

   // per-context register offsets
   // status is read only, clear is write only
   typedef enum logic [`INTR_OFF_W-1:0] {
      REG_STATUS = 4'd1,
      REG_CLEAR  = 4'd2,
      REG_MASK   = 4'd3,
      REG_CTRL   = 4'd8
   } reg_off_t;

   typedef logic [`INTR_DATA_W-1:0] mmio_data_t;

   // word address, context in the upper bits and offset below
   typedef logic [`INTR_CTXT_W+`INTR_OFF_W-1:0] mmio_adr_t;

endpackage

//--- source/ctxt_ram.sv
`timescale 1ns/10ps
`include "intr_ctrl_params.svh"

// one entry per context, registered read
module ctxt_ram #(
   parameter type T = logic
) (
   input  logic                    i_clk,
   input  logic                    i_re,
   input  logic [`INTR_CTXT_W-1:0] i_ra,
   output T                        o_rd,
   input  logic                    i_we,
   input  logic [`INTR_CTXT_W-1:0] i_wa,
   input  T                        i_wd
);

   T mem [`INTR_NCTXT];

   always_ff @(posedge i_clk) begin
      if (i_we) begin
         mem[i_wa] <= i_wd;
      end
      // read returns the old entry on a same-address write
      if (i_re) begin
         o_rd <= mem[i_ra];
      end
   end

endmodule

//--- source/intr_update_pipe.sv
`timescale 1ns/10ps
`include "intr_ctrl_params.svh"

module intr_update_pipe
   import intr_types_pkg::*;
   import intr_regs_pkg::*;
(
   input  logic       i_clk,
   input  logic       i_rst,
   input  logic       i_ctxt_add_v,
   input  ctxt_t      i_ctxt_add_ctxt,
   output logic       o_ctxt_add_r,
   input  logic       i_err_v,
   input  ctxt_t      i_err_ctxt,
   input  src_id_t    i_err_src,
   output logic       o_err_r,
   input  logic       i_wr_v,
   input  ctxt_t      i_wr_ctxt,
   input  reg_off_t   i_wr_off,
   input  mmio_data_t i_wr_dat,
   output logic       o_wr_r,
   output ctxt_t      o_upd_ctxt,
   output logic       o_stat_we,
   output src_vec_t   o_stat_wd,
   output logic       o_mask_we,
   output src_vec_t   o_mask_wd,
   output logic       o_msi_we,
   output msi_t       o_msi_wd,
   output logic       o_irq_set,
   output logic       o_add_done,
   output logic       o_wr_done
);

   logic       s1_gate, s1_acc;
   upd_kind_t  s1_kind;
   ctxt_t      s1_ctxt;
   logic       s2_v, s3_v;
   upd_kind_t  s2_kind, s3_kind;
   ctxt_t      s2_ctxt, s3_ctxt;
   reg_off_t   s2_off, s3_off;
   mmio_data_t s2_dat, s3_dat;
   src_id_t    s2_src, s3_src;
   src_vec_t   s2_stat, s2_msk, s3_stat, s3_msk;
   src_vec_t   s3_src_vec, s3_clr_stat;
   logic       s3_irq;

   // one update in flight, the gate opens once stage 3 has committed
   assign s1_gate = ~s2_v & ~s3_v;
   assign o_ctxt_add_r = s1_gate & i_ctxt_add_v;
   assign o_wr_r = s1_gate & ~i_ctxt_add_v & i_wr_v;
   assign o_err_r = s1_gate & ~i_ctxt_add_v & ~i_wr_v & i_err_v;
   assign s1_acc = o_ctxt_add_r | o_wr_r | o_err_r;

   always_comb begin
      s1_kind = UPD_ERR;
      s1_ctxt = i_err_ctxt;
      if (i_ctxt_add_v) begin
         s1_kind = UPD_ADD;
         s1_ctxt = i_ctxt_add_ctxt;
      end else if (i_wr_v) begin
         s1_kind = UPD_WR;
         s1_ctxt = i_wr_ctxt;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         s2_v <= 1'b0;
         s3_v <= 1'b0;
      end else begin
         s2_v <= s1_acc;
         s3_v <= s2_v;
      end
   end

   always_ff @(posedge i_clk) begin
      if (s1_acc) begin
         s2_kind <= s1_kind;
         s2_ctxt <= s1_ctxt;
         s2_off  <= i_wr_off;
         s2_dat  <= i_wr_dat;
         s2_src  <= i_err_src;
      end
      if (s2_v) begin
         s3_kind <= s2_kind;
         s3_ctxt <= s2_ctxt;
         s3_off  <= s2_off;
         s3_dat  <= s2_dat;
         s3_src  <= s2_src;
         s3_stat <= s2_stat;
         s3_msk  <= s2_msk;
      end
   end

   // status and mask come out during stage 2
   ctxt_ram #(.T(src_vec_t)) u_stat_ram (
      .i_clk(i_clk), .i_re(s1_acc), .i_ra(s1_ctxt), .o_rd(s2_stat),
      .i_we(o_stat_we), .i_wa(s3_ctxt), .i_wd(o_stat_wd)
   );

   ctxt_ram #(.T(src_vec_t)) u_mask_ram (
      .i_clk(i_clk), .i_re(s1_acc), .i_ra(s1_ctxt), .o_rd(s2_msk),
      .i_we(o_mask_we), .i_wa(s3_ctxt), .i_wd(o_mask_wd)
   );

   assign s3_src_vec = src_vec_t'(1) << s3_src;
   assign s3_clr_stat = s3_stat & ~s3_dat[`INTR_NSRC-1:0];

   // stage 3 update rules
   always_comb begin
      o_stat_we = 1'b0;
      o_stat_wd = s3_stat;
      o_mask_we = 1'b0;
      o_mask_wd = s3_msk;
      o_msi_we  = 1'b0;
      o_msi_wd  = s3_dat[`INTR_MSI_W-1:0];
      s3_irq    = 1'b0;
      case (s3_kind)
         UPD_ADD: begin
            o_stat_we = 1'b1;
            o_stat_wd = '0;
            o_mask_we = 1'b1;
            o_mask_wd = '1;
            o_msi_we  = 1'b1;
            o_msi_wd  = '0;
         end
         UPD_WR: begin
            case (s3_off)
               REG_CLEAR: begin
                  o_stat_we = 1'b1;
                  o_stat_wd = s3_clr_stat;
                  s3_irq    = |(s3_clr_stat & ~s3_msk);
               end
               REG_MASK: begin
                  o_mask_we = 1'b1;
                  o_mask_wd = s3_dat[`INTR_NSRC-1:0];
               end
               REG_CTRL: o_msi_we = 1'b1;
               default: ;
            endcase
         end
         UPD_ERR: begin
            o_stat_we = 1'b1;
            o_stat_wd = s3_stat | s3_src_vec;
            // only a newly set, unmasked source raises
            s3_irq    = |(s3_src_vec & ~s3_stat & ~s3_msk);
         end
         default: ;
      endcase
      o_stat_we = o_stat_we & s3_v;
      o_mask_we = o_mask_we & s3_v;
      o_msi_we  = o_msi_we & s3_v;
   end

   assign o_upd_ctxt = s3_ctxt;
   assign o_irq_set  = s3_v & s3_irq;
   assign o_add_done = s3_v & (s3_kind == UPD_ADD);
   assign o_wr_done  = s3_v & (s3_kind == UPD_WR);

   a_one_in_flight: assert property (@(posedge i_clk) disable iff (i_rst)
      !(s2_v && s3_v));

endmodule

//--- source/intr_scanner.sv
`timescale 1ns/10ps
`include "intr_ctrl_params.svh"

module intr_scanner
   import intr_types_pkg::*;
(
   input  logic  i_clk,
   input  logic  i_rst,
   input  ctxt_t i_upd_ctxt,
   input  logic  i_irq_set,
   input  logic  i_add_done,
   input  logic  i_msi_we,
   input  msi_t  i_msi_wd,
   output logic  o_intr_v,
   output ctxt_t o_intr_ctxt,
   output msi_t  o_intr_msi,
   input  logic  i_intr_r
);

   logic [`INTR_NCTXT-1:0] pend;
   ctxt_t                  scan_ctxt, scan_next, msi_ra;
   msi_t                   msi_rd;
   logic                   out_free, take;

   // output register can load when empty or draining
   assign out_free = ~o_intr_v | i_intr_r;
   assign take = out_free & pend[scan_ctxt];

   // wraps after the last context
   assign scan_next = scan_ctxt + ctxt_t'(1);

   // address the entry the pointer holds next cycle
   assign msi_ra = out_free ? scan_next : scan_ctxt;

   ctxt_ram #(.T(msi_t)) u_msi_ram (
      .i_clk(i_clk), .i_re(1'b1), .i_ra(msi_ra), .o_rd(msi_rd),
      .i_we(i_msi_we), .i_wa(i_upd_ctxt), .i_wd(i_msi_wd)
   );

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         pend <= '0;
      end else begin
         if (take) begin
            pend[scan_ctxt] <= 1'b0;
         end
         if (i_add_done) begin
            pend[i_upd_ctxt] <= 1'b0;
         end
         // a raise landing on delivery stays pending
         if (i_irq_set) begin
            pend[i_upd_ctxt] <= 1'b1;
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         scan_ctxt <= '0;
         o_intr_v  <= 1'b0;
      end else if (out_free) begin
         scan_ctxt <= scan_next;
         o_intr_v  <= pend[scan_ctxt];
      end
   end

   always_ff @(posedge i_clk) begin
      if (take) begin
         o_intr_ctxt <= scan_ctxt;
         o_intr_msi  <= msi_rd;
      end
   end

   a_intr_hold: assert property (@(posedge i_clk) disable iff (i_rst)
      o_intr_v && !i_intr_r |=> o_intr_v && $stable(o_intr_ctxt) && $stable(o_intr_msi));

endmodule

//--- source/mmio_regs.sv
`timescale 1ns/10ps
`include "intr_ctrl_params.svh"

module mmio_regs
   import intr_types_pkg::*;
   import intr_regs_pkg::*;
(
   input  logic       i_clk,
   input  logic       i_rst,
   input  logic       i_wb_cyc,
   input  logic       i_wb_stb,
   input  logic       i_wb_we,
   input  mmio_adr_t  i_wb_adr,
   input  mmio_data_t i_wb_dat,
   output mmio_data_t o_wb_dat,
   output logic       o_wb_ack,
   output logic       o_wr_v,
   output ctxt_t      o_wr_ctxt,
   output reg_off_t   o_wr_off,
   output mmio_data_t o_wr_dat,
   input  logic       i_wr_r,
   input  logic       i_wr_done,
   input  ctxt_t      i_upd_ctxt,
   input  logic       i_stat_we,
   input  src_vec_t   i_stat_wd,
   input  logic       i_mask_we,
   input  src_vec_t   i_mask_wd,
   input  logic       i_msi_we,
   input  msi_t       i_msi_wd
);

   ctxt_t                   wb_ctxt;
   logic [`INTR_OFF_W-1:0]  wb_off, rd_off;
   logic                    off_known, busy, start, rd_start, wr_start, bad_start, rd_p1;
   src_vec_t                stat_rd, mask_rd;
   msi_t                    msi_rd;
   mmio_data_t              rd_mux;

   assign wb_ctxt = i_wb_adr[`INTR_CTXT_W+`INTR_OFF_W-1:`INTR_OFF_W];
   assign wb_off  = i_wb_adr[`INTR_OFF_W-1:0];

   always_comb begin
      case (wb_off)
         REG_STATUS, REG_CLEAR, REG_MASK, REG_CTRL: off_known = 1'b1;
         default: off_known = 1'b0;
      endcase
   end

   // master holds the cycle until ack, so a new one starts after it
   assign start     = i_wb_cyc & i_wb_stb & ~busy & ~o_wb_ack;
   assign rd_start  = start & ~i_wb_we;
   assign wr_start  = start & i_wb_we & off_known;
   assign bad_start = start & i_wb_we & ~off_known;

   // bus holds address and data while the write waits
   assign o_wr_ctxt = wb_ctxt;
   assign o_wr_off  = reg_off_t'(wb_off);
   assign o_wr_dat  = i_wb_dat;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         busy     <= 1'b0;
         o_wr_v   <= 1'b0;
         rd_p1    <= 1'b0;
         o_wb_ack <= 1'b0;
      end else begin
         rd_p1 <= rd_start;
         // writes ack after the pipeline commit
         o_wb_ack <= rd_p1 | i_wr_done | bad_start;
         if (wr_start) begin
            o_wr_v <= 1'b1;
         end else if (o_wr_v & i_wr_r) begin
            o_wr_v <= 1'b0;
         end
         if (o_wb_ack) begin
            busy <= 1'b0;
         end else if (start) begin
            busy <= 1'b1;
         end
      end
   end

   // read copies of status, mask and msi
   ctxt_ram #(.T(src_vec_t)) u_stat_ram (
      .i_clk(i_clk), .i_re(rd_start), .i_ra(wb_ctxt), .o_rd(stat_rd),
      .i_we(i_stat_we), .i_wa(i_upd_ctxt), .i_wd(i_stat_wd)
   );

   ctxt_ram #(.T(src_vec_t)) u_mask_ram (
      .i_clk(i_clk), .i_re(rd_start), .i_ra(wb_ctxt), .o_rd(mask_rd),
      .i_we(i_mask_we), .i_wa(i_upd_ctxt), .i_wd(i_mask_wd)
   );

   ctxt_ram #(.T(msi_t)) u_msi_ram (
      .i_clk(i_clk), .i_re(rd_start), .i_ra(wb_ctxt), .o_rd(msi_rd),
      .i_we(i_msi_we), .i_wa(i_upd_ctxt), .i_wd(i_msi_wd)
   );

   always_comb begin
      case (rd_off)
         REG_STATUS: rd_mux = {{(`INTR_DATA_W-`INTR_NSRC){1'b0}}, stat_rd};
         REG_MASK:   rd_mux = {{(`INTR_DATA_W-`INTR_NSRC){1'b0}}, mask_rd};
         REG_CTRL:   rd_mux = {{(`INTR_DATA_W-`INTR_MSI_W){1'b0}}, msi_rd};
         default:    rd_mux = '0;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (rd_start) begin
         rd_off <= wb_off;
      end
      if (rd_p1) begin
         o_wb_dat <= rd_mux;
      end
   end

   a_ack_in_cycle: assert property (@(posedge i_clk) disable iff (i_rst)
      o_wb_ack |-> i_wb_cyc && i_wb_stb);

endmodule

//--- source/intr_ctrl_top.sv
`timescale 1ns/10ps

module intr_ctrl_top
   import intr_types_pkg::*;
   import intr_regs_pkg::*;
(
   input  logic       i_clk,
   input  logic       i_rst,
   input  logic       i_wb_cyc,
   input  logic       i_wb_stb,
   input  logic       i_wb_we,
   input  mmio_adr_t  i_wb_adr,
   input  mmio_data_t i_wb_dat,
   output mmio_data_t o_wb_dat,
   output logic       o_wb_ack,
   input  logic       i_ctxt_add_v,
   input  ctxt_t      i_ctxt_add_ctxt,
   output logic       o_ctxt_add_r,
   input  logic       i_err_v,
   input  ctxt_t      i_err_ctxt,
   input  src_id_t    i_err_src,
   output logic       o_err_r,
   output logic       o_intr_v,
   output ctxt_t      o_intr_ctxt,
   output msi_t       o_intr_msi,
   input  logic       i_intr_r
);

   logic       wr_v, wr_r, wr_done;
   ctxt_t      wr_ctxt, upd_ctxt;
   reg_off_t   wr_off;
   mmio_data_t wr_dat;
   logic       stat_we, mask_we, msi_we, irq_set, add_done;
   src_vec_t   stat_wd, mask_wd;
   msi_t       msi_wd;

   intr_update_pipe u_pipe (
      .i_clk(i_clk), .i_rst(i_rst),
      .i_ctxt_add_v(i_ctxt_add_v), .i_ctxt_add_ctxt(i_ctxt_add_ctxt),
      .o_ctxt_add_r(o_ctxt_add_r),
      .i_err_v(i_err_v), .i_err_ctxt(i_err_ctxt), .i_err_src(i_err_src), .o_err_r(o_err_r),
      .i_wr_v(wr_v), .i_wr_ctxt(wr_ctxt), .i_wr_off(wr_off), .i_wr_dat(wr_dat), .o_wr_r(wr_r),
      .o_upd_ctxt(upd_ctxt),
      .o_stat_we(stat_we), .o_stat_wd(stat_wd),
      .o_mask_we(mask_we), .o_mask_wd(mask_wd),
      .o_msi_we(msi_we), .o_msi_wd(msi_wd),
      .o_irq_set(irq_set), .o_add_done(add_done), .o_wr_done(wr_done)
   );

   intr_scanner u_scan (
      .i_clk(i_clk), .i_rst(i_rst),
      .i_upd_ctxt(upd_ctxt), .i_irq_set(irq_set), .i_add_done(add_done),
      .i_msi_we(msi_we), .i_msi_wd(msi_wd),
      .o_intr_v(o_intr_v), .o_intr_ctxt(o_intr_ctxt), .o_intr_msi(o_intr_msi),
      .i_intr_r(i_intr_r)
   );

   mmio_regs u_mmio (
      .i_clk(i_clk), .i_rst(i_rst),
      .i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb), .i_wb_we(i_wb_we),
      .i_wb_adr(i_wb_adr), .i_wb_dat(i_wb_dat), .o_wb_dat(o_wb_dat), .o_wb_ack(o_wb_ack),
      .o_wr_v(wr_v), .o_wr_ctxt(wr_ctxt), .o_wr_off(wr_off), .o_wr_dat(wr_dat),
      .i_wr_r(wr_r), .i_wr_done(wr_done),
      .i_upd_ctxt(upd_ctxt),
      .i_stat_we(stat_we), .i_stat_wd(stat_wd),
      .i_mask_we(mask_we), .i_mask_wd(mask_wd),
      .i_msi_we(msi_we), .i_msi_wd(msi_wd)
   );

endmodule

//--- verif/intr_ctrl_tb.sv
`timescale 1ns/10ps
`include "intr_ctrl_params.svh"

module intr_ctrl_tb
   import intr_types_pkg::*;
   import intr_regs_pkg::*;
();

   localparam int TIMEOUT = 200;
   // longer than one full scan of all contexts
   localparam int QUIET = `INTR_NCTXT + 8;

   typedef enum logic [3:0] {
      OP_ADD, OP_WR, OP_RD, OP_ERR, OP_INTR, OP_NONE, OP_STALL, OP_FREE, OP_STEADY
   } op_t;

   // sel is the register offset, or the source number for an error
   typedef struct packed {
      op_t        op;
      ctxt_t      ctxt;
      logic [3:0] sel;
      mmio_data_t dat;
      mmio_data_t exp;
   } step_t;

   typedef struct packed {
      ctxt_t ctxt;
      msi_t  msi;
   } intr_rec_t;

   logic       i_clk, i_rst;
   logic       i_wb_cyc, i_wb_stb, i_wb_we;
   mmio_adr_t  i_wb_adr;
   mmio_data_t i_wb_dat, o_wb_dat;
   logic       o_wb_ack;
   logic       i_ctxt_add_v, o_ctxt_add_r;
   ctxt_t      i_ctxt_add_ctxt;
   logic       i_err_v, o_err_r;
   ctxt_t      i_err_ctxt;
   src_id_t    i_err_src;
   logic       o_intr_v, i_intr_r;
   ctxt_t      o_intr_ctxt;
   msi_t       o_intr_msi;

   int         err_cnt, tmo_cnt;
   step_t      steps [$];
   intr_rec_t  intr_q [$];

   intr_ctrl_top u_dut (
      .i_clk(i_clk), .i_rst(i_rst),
      .i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb), .i_wb_we(i_wb_we),
      .i_wb_adr(i_wb_adr), .i_wb_dat(i_wb_dat), .o_wb_dat(o_wb_dat), .o_wb_ack(o_wb_ack),
      .i_ctxt_add_v(i_ctxt_add_v), .i_ctxt_add_ctxt(i_ctxt_add_ctxt),
      .o_ctxt_add_r(o_ctxt_add_r),
      .i_err_v(i_err_v), .i_err_ctxt(i_err_ctxt), .i_err_src(i_err_src), .o_err_r(o_err_r),
      .o_intr_v(o_intr_v), .o_intr_ctxt(o_intr_ctxt), .o_intr_msi(o_intr_msi),
      .i_intr_r(i_intr_r)
   );

   always #2 i_clk = ~i_clk;

   // interrupts seen here transfer at the next rising edge
   always @(negedge i_clk) begin
      #1;
      if (!i_rst && o_intr_v && i_intr_r) begin
         intr_q.push_back({o_intr_ctxt, o_intr_msi});
      end
   end

   task automatic report_mismatch(input string name, input mmio_data_t got,
                                  input mmio_data_t exp);
      $display("[FAIL] %0d ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      err_cnt++;
   endtask

   task automatic report_timeout(input string what);
      $display("[FAIL] %0d ns: timed out waiting for %s", $time, what);
      tmo_cnt++;
   endtask

   function automatic step_t make_step(input op_t op, input ctxt_t c, input logic [3:0] sel,
                                       input mmio_data_t dat, input mmio_data_t exp);
      step_t s;
      s.op   = op;
      s.ctxt = c;
      s.sel  = sel;
      s.dat  = dat;
      s.exp  = exp;
      return s;
   endfunction

   function automatic int find_intr(input ctxt_t c);
      int idx;
      idx = -1;
      foreach (intr_q[i]) begin
         if (idx < 0 && intr_q[i].ctxt == c) begin
            idx = i;
         end
      end
      return idx;
   endfunction

   // commit lands two cycles after acceptance
   task automatic drain_pipe();
      repeat (3) @(negedge i_clk);
   endtask

   task automatic wb_access(input logic we, input ctxt_t c, input logic [3:0] off,
                            input mmio_data_t d, output mmio_data_t rd);
      int n;
      n = 0;
      i_wb_cyc = 1'b1;
      i_wb_stb = 1'b1;
      i_wb_we  = we;
      i_wb_adr = {c, off};
      i_wb_dat = d;
      @(negedge i_clk);
      while (!o_wb_ack && n < TIMEOUT) begin
         @(negedge i_clk);
         n++;
      end
      if (!o_wb_ack)
         report_timeout("wishbone ack");
      else if (!we && n != 1)
         report_mismatch("o_wb_ack read latency", n + 1, 2);
      rd = o_wb_dat;
      // strobe stays up through the edge that samples ack
      @(negedge i_clk);
      if (o_wb_ack !== 1'b0)
         report_mismatch("o_wb_ack", o_wb_ack, 0);
      i_wb_cyc = 1'b0;
      i_wb_stb = 1'b0;
      i_wb_we  = 1'b0;
   endtask

   task automatic send_add(input ctxt_t c);
      int n;
      n = 0;
      i_ctxt_add_v    = 1'b1;
      i_ctxt_add_ctxt = c;
      #1;
      while (!o_ctxt_add_r && n < TIMEOUT) begin
         @(negedge i_clk);
         #1;
         n++;
      end
      if (!o_ctxt_add_r)
         report_timeout("context add ready");
      @(negedge i_clk);
      i_ctxt_add_v = 1'b0;
      drain_pipe();
   endtask

   task automatic send_err(input ctxt_t c, input src_id_t src);
      int n;
      n = 0;
      i_err_v    = 1'b1;
      i_err_ctxt = c;
      i_err_src  = src;
      #1;
      while (!o_err_r && n < TIMEOUT) begin
         @(negedge i_clk);
         #1;
         n++;
      end
      if (!o_err_r)
         report_timeout("error event ready");
      @(negedge i_clk);
      i_err_v = 1'b0;
      drain_pipe();
   endtask

   // delivery order between contexts is free, so match by context
   task automatic expect_intr(input ctxt_t c, input msi_t m);
      int n, idx;
      n = 0;
      idx = find_intr(c);
      while (idx < 0 && n < TIMEOUT) begin
         @(negedge i_clk);
         n++;
         idx = find_intr(c);
      end
      if (idx < 0) begin
         report_timeout($sformatf("an interrupt from context %0d", c));
      end else begin
         if (intr_q[idx].msi !== m)
            report_mismatch("o_intr_msi", intr_q[idx].msi, m);
         intr_q.delete(idx);
      end
   endtask

   task automatic check_quiet();
      repeat (QUIET) @(negedge i_clk);
      if (intr_q.size() != 0) begin
         report_mismatch("o_intr_v count", intr_q.size(), 0);
         intr_q.delete();
      end
   endtask

   task automatic check_steady();
      int n;
      intr_rec_t held;
      n = 0;
      while (!o_intr_v && n < TIMEOUT) begin
         @(negedge i_clk);
         n++;
      end
      if (!o_intr_v)
         report_timeout("o_intr_v under back-pressure");
      held.ctxt = o_intr_ctxt;
      held.msi  = o_intr_msi;
      repeat (QUIET) begin
         @(negedge i_clk);
         if (o_intr_v !== 1'b1)
            report_mismatch("o_intr_v", o_intr_v, 1);
         if (o_intr_ctxt !== held.ctxt)
            report_mismatch("o_intr_ctxt", o_intr_ctxt, held.ctxt);
         if (o_intr_msi !== held.msi)
            report_mismatch("o_intr_msi", o_intr_msi, held.msi);
      end
   endtask

   task automatic run_step(input step_t s);
      mmio_data_t rd;
      case (s.op)
         OP_ADD: send_add(s.ctxt);
         OP_ERR: send_err(s.ctxt, src_id_t'(s.sel));
         OP_WR:  wb_access(1'b1, s.ctxt, s.sel, s.dat, rd);
         OP_RD: begin
            wb_access(1'b0, s.ctxt, s.sel, '0, rd);
            if (rd !== s.exp)
               report_mismatch($sformatf("o_wb_dat ctxt %0d off %0d", s.ctxt, s.sel), rd, s.exp);
         end
         OP_INTR:   expect_intr(s.ctxt, msi_t'(s.exp));
         OP_NONE:   check_quiet();
         OP_STALL:  i_intr_r = 1'b0;
         OP_FREE:   i_intr_r = 1'b1;
         OP_STEADY: check_steady();
         default: ;
      endcase
   endtask

   task automatic build_table();
      // reset and context add defaults
      steps.push_back(make_step(OP_NONE,  4'd0, 4'd0, 64'h0, 64'h0));
      steps.push_back(make_step(OP_ADD,   4'd3, 4'd0, 64'h0, 64'h0));
      steps.push_back(make_step(OP_RD,    4'd3, 4'd1, 64'h0, 64'h0));
      steps.push_back(make_step(OP_RD,    4'd3, 4'd3, 64'h0, 64'h3f));
      steps.push_back(make_step(OP_RD,    4'd3, 4'd8, 64'h0, 64'h0));
      // mask 0x2a leaves sources 0, 2 and 4 open
      steps.push_back(make_step(OP_WR,    4'd3, 4'd3, 64'hffff_ffff_ffff_ffea, 64'h0));
      steps.push_back(make_step(OP_RD,    4'd3, 4'd3, 64'h0, 64'h2a));
      steps.push_back(make_step(OP_WR,    4'd3, 4'd8, 64'h1234_5678_9abc_de5a, 64'h0));
      steps.push_back(make_step(OP_RD,    4'd3, 4'd8, 64'h0, 64'h5a));
      steps.push_back(make_step(OP_RD,    4'd3, 4'd2, 64'h0, 64'h0));
      steps.push_back(make_step(OP_WR,    4'd3, 4'd5, 64'hffff, 64'h0));
      steps.push_back(make_step(OP_RD,    4'd3, 4'd5, 64'h0, 64'h0));
      steps.push_back(make_step(OP_RD,    4'd3, 4'd3, 64'h0, 64'h2a));
      // unmasked error, then the same one again
      steps.push_back(make_step(OP_ERR,   4'd3, 4'd2, 64'h0, 64'h0));
      steps.push_back(make_step(OP_INTR,  4'd3, 4'd0, 64'h0, 64'h5a));
      steps.push_back(make_step(OP_RD,    4'd3, 4'd1, 64'h0, 64'h04));
      steps.push_back(make_step(OP_ERR,   4'd3, 4'd2, 64'h0, 64'h0));
      steps.push_back(make_step(OP_NONE,  4'd0, 4'd0, 64'h0, 64'h0));
      // masked error and clear writes
      steps.push_back(make_step(OP_ERR,   4'd3, 4'd3, 64'h0, 64'h0));
      steps.push_back(make_step(OP_NONE,  4'd0, 4'd0, 64'h0, 64'h0));
      steps.push_back(make_step(OP_RD,    4'd3, 4'd1, 64'h0, 64'h0c));
      steps.push_back(make_step(OP_WR,    4'd3, 4'd2, 64'h08, 64'h0));
      steps.push_back(make_step(OP_INTR,  4'd3, 4'd0, 64'h0, 64'h5a));
      steps.push_back(make_step(OP_RD,    4'd3, 4'd1, 64'h0, 64'h04));
      steps.push_back(make_step(OP_WR,    4'd3, 4'd2, 64'h3f, 64'h0));
      steps.push_back(make_step(OP_RD,    4'd3, 4'd1, 64'h0, 64'h0));
      steps.push_back(make_step(OP_NONE,  4'd0, 4'd0, 64'h0, 64'h0));
      // two contexts behind a stalled output
      steps.push_back(make_step(OP_ADD,   4'd5, 4'd0, 64'h0, 64'h0));
      steps.push_back(make_step(OP_ADD,   4'd9, 4'd0, 64'h0, 64'h0));
      steps.push_back(make_step(OP_WR,    4'd5, 4'd3, 64'h0, 64'h0));
      steps.push_back(make_step(OP_WR,    4'd9, 4'd3, 64'h0, 64'h0));
      steps.push_back(make_step(OP_WR,    4'd5, 4'd8, 64'h71, 64'h0));
      steps.push_back(make_step(OP_WR,    4'd9, 4'd8, 64'h93, 64'h0));
      steps.push_back(make_step(OP_STALL, 4'd0, 4'd0, 64'h0, 64'h0));
      steps.push_back(make_step(OP_ERR,   4'd5, 4'd0, 64'h0, 64'h0));
      steps.push_back(make_step(OP_ERR,   4'd9, 4'd4, 64'h0, 64'h0));
      steps.push_back(make_step(OP_STEADY, 4'd0, 4'd0, 64'h0, 64'h0));
      steps.push_back(make_step(OP_FREE,  4'd0, 4'd0, 64'h0, 64'h0));
      steps.push_back(make_step(OP_INTR,  4'd5, 4'd0, 64'h0, 64'h71));
      steps.push_back(make_step(OP_INTR,  4'd9, 4'd0, 64'h0, 64'h93));
      steps.push_back(make_step(OP_NONE,  4'd0, 4'd0, 64'h0, 64'h0));
      // context 9 holds the output while context 5 is added back
      steps.push_back(make_step(OP_STALL, 4'd0, 4'd0, 64'h0, 64'h0));
      steps.push_back(make_step(OP_ERR,   4'd9, 4'd1, 64'h0, 64'h0));
      steps.push_back(make_step(OP_STEADY, 4'd0, 4'd0, 64'h0, 64'h0));
      steps.push_back(make_step(OP_ERR,   4'd5, 4'd5, 64'h0, 64'h0));
      steps.push_back(make_step(OP_ADD,   4'd5, 4'd0, 64'h0, 64'h0));
      steps.push_back(make_step(OP_FREE,  4'd0, 4'd0, 64'h0, 64'h0));
      steps.push_back(make_step(OP_INTR,  4'd9, 4'd0, 64'h0, 64'h93));
      steps.push_back(make_step(OP_NONE,  4'd0, 4'd0, 64'h0, 64'h0));
      steps.push_back(make_step(OP_RD,    4'd5, 4'd1, 64'h0, 64'h0));
      steps.push_back(make_step(OP_RD,    4'd5, 4'd3, 64'h0, 64'h3f));
      steps.push_back(make_step(OP_RD,    4'd5, 4'd8, 64'h0, 64'h0));
   endtask

   initial begin
      err_cnt         = 0;
      tmo_cnt         = 0;
      i_clk           = 1'b0;
      i_rst           = 1'b1;
      i_wb_cyc        = 1'b0;
      i_wb_stb        = 1'b0;
      i_wb_we         = 1'b0;
      i_wb_adr        = '0;
      i_wb_dat        = '0;
      i_ctxt_add_v    = 1'b0;
      i_ctxt_add_ctxt = '0;
      i_err_v         = 1'b0;
      i_err_ctxt      = '0;
      i_err_src       = '0;
      i_intr_r        = 1'b1;
      build_table();
      repeat (10) @(posedge i_clk);
      @(negedge i_clk);
      i_rst = 1'b0;
      @(negedge i_clk);
      foreach (steps[i]) begin
         run_step(steps[i]);
      end
      if (intr_q.size() != 0)
         report_mismatch("o_intr_v count", intr_q.size(), 0);
      $display("errors: %0d mismatches, %0d timeouts", err_cnt, tmo_cnt);
      if (err_cnt == 0 && tmo_cnt == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

//--- intr_ctrl.f
+incdir+source
source/intr_types_pkg.sv
source/intr_regs_pkg.sv
source/ctxt_ram.sv
source/intr_update_pipe.sv
source/intr_scanner.sv
source/mmio_regs.sv
source/intr_ctrl_top.sv
verif/intr_ctrl_tb.sv

//--- Bender.yml
package:
  name: intr_ctrl

sources:
  - include_dirs:
      - source
    files:
      - source/intr_types_pkg.sv
      - source/intr_regs_pkg.sv
      - source/ctxt_ram.sv
      - source/intr_update_pipe.sv
      - source/intr_scanner.sv
      - source/mmio_regs.sv
      - source/intr_ctrl_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/intr_ctrl_tb.sv
